// File: include/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// ----------------------------------------
// Core widths
// ----------------------------------------

`define CORE_XLEN        64    // Data path width
`define CORE_REG_ADDR_W  5     // GPR index width
`define CORE_CSR_ADDR_W  12    // CSR address width

// ----------------------------------------
// Data memory
// ----------------------------------------

`define CORE_DMEM_DEPTH  64    // Doublewords in the data SRAM

`endif

// File: source/core_pkg.sv
`include "core_cfg.svh"

package core_pkg;

    localparam int DMEM_AW = $clog2(`CORE_DMEM_DEPTH);  // SRAM word index width

    // ----------------------------------------
    // Operation encodings
    // ----------------------------------------

    typedef struct packed {
        logic load;        // Memory read
        logic store;       // Memory write
        logic sz_byte;     // 8-bit access
        logic sz_half;     // 16-bit access
        logic sz_word;     // 32-bit access
        logic sz_double;   // 64-bit access
        logic sext;        // Sign extend load data
    } lsu_op_t;

    typedef struct packed {
        logic rd;          // Read only
        logic wr;          // Overwrite
        logic set;         // OR in bits
        logic clr;         // Clear bits
    } csr_op_t;

    typedef enum logic [1:0] {
        WB_OP_NONE  = 2'd0,  // No GPR write
        WB_OP_WDATA = 2'd1,  // Execute value
        WB_OP_LSU   = 2'd2,  // Load data
        WB_OP_CSR   = 2'd3   // Old CSR value
    } wb_op_t;

    // Execute result, either a value or a memory address
    typedef union packed {
        logic [`CORE_XLEN-1:0] value;
        struct packed {
            logic [`CORE_XLEN-4:0] dw_idx;  // Doubleword index
            logic [2:0]            offset;  // Byte within doubleword
        } addr;
    } result_u;

    // ----------------------------------------
    // Pipeline and port bundles
    // ----------------------------------------

    typedef struct packed {
        logic [`CORE_XLEN-1:0]       pc;
        logic [31:0]                 instr;
        result_u                     result;
        logic [`CORE_XLEN-1:0]       store_data;
        logic [`CORE_REG_ADDR_W-1:0] rd;
        lsu_op_t                     lsu_op;
        csr_op_t                     csr_op;
        logic [`CORE_CSR_ADDR_W-1:0] csr_addr;
        wb_op_t                      wb_op;
    } instr_pkt_t;

    typedef struct packed {
        logic                        wen;
        logic [`CORE_REG_ADDR_W-1:0] addr;
        logic [`CORE_XLEN-1:0]       wdata;
    } gpr_wr_t;

    typedef struct packed {
        logic                        en;
        logic                        wr;
        logic                        set;
        logic                        clr;
        logic [`CORE_CSR_ADDR_W-1:0] addr;
        logic [`CORE_XLEN-1:0]       wdata;
    } csr_req_t;

    typedef struct packed {
        logic                  valid;
        logic [31:0]           instr;
        logic [`CORE_XLEN-1:0] pc;
    } trace_t;

    typedef struct packed {
        logic                  req;
        logic                  wen;
        logic [7:0]            strb;   // One bit per byte lane
        logic [DMEM_AW-1:0]    addr;
        logic [`CORE_XLEN-1:0] wdata;
    } dmem_req_t;

endpackage

// File: source/core_pipe_mem.sv
`timescale 1ns/1ps

module core_pipe_mem (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  iss_req,    // Issue request
    input  core_pkg::instr_pkt_t  iss_pkt,    // Stable while iss_req high
    input  logic                  s2_ready,   // Stage 3 can take a packet
    output logic                  iss_ack,    // Issue acknowledge
    output logic                  s2_valid,   // Held packet present
    output core_pkg::instr_pkt_t  s2_pkt,
    output core_pkg::dmem_req_t   dmem        // Data SRAM request
);

    typedef enum logic {
        HS_IDLE,     // Waiting for iss_req
        HS_ACK       // Acked, waiting for iss_req to drop
    } hs_state_t;

    hs_state_t            hs_state;
    logic                 full_q;           // Holding register occupied
    core_pkg::instr_pkt_t pkt_q;            // Held packet

    logic                 drain;            // Packet moves to stage 3
    logic                 can_take;         // Room at the next edge
    logic                 take;             // Capture issue packet
    logic [7:0]           strb_base;        // Unshifted store strobe
    logic [2:0]           offs;             // Byte offset of access

    // ----------------------------------------
    // Four-phase receive
    // ----------------------------------------

    assign drain    = full_q && s2_ready;
    assign can_take = !full_q || drain;     // Back to back when draining
    assign take     = (hs_state == HS_IDLE) && iss_req && can_take;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            hs_state <= HS_IDLE;
            full_q   <= 1'b0;
        end else begin
            case (hs_state)
                HS_IDLE: if (take)     hs_state <= HS_ACK;
                HS_ACK:  if (!iss_req) hs_state <= HS_IDLE;  // Ack falls next cycle
                default:               hs_state <= HS_IDLE;
            endcase
            if (take) begin
                full_q <= 1'b1;
            end else if (drain) begin
                full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (take) begin
            pkt_q <= iss_pkt;               // Payload, no reset
        end
    end

    assign iss_ack  = (hs_state == HS_ACK);
    assign s2_valid = full_q;
    assign s2_pkt   = pkt_q;

    // ----------------------------------------
    // Data SRAM request
    // ----------------------------------------

    assign offs = pkt_q.result.addr.offset;

    always_comb begin
        if (pkt_q.lsu_op.sz_byte) begin
            strb_base = 8'h01;
        end else if (pkt_q.lsu_op.sz_half) begin
            strb_base = 8'h03;
        end else if (pkt_q.lsu_op.sz_word) begin
            strb_base = 8'h0f;
        end else begin
            strb_base = 8'hff;              // Doubleword
        end
    end

    always_comb begin
        dmem.req   = drain && (pkt_q.lsu_op.load || pkt_q.lsu_op.store);
        dmem.wen   = drain && pkt_q.lsu_op.store;
        dmem.strb  = strb_base << offs;     // Lanes of the access
        dmem.addr  = pkt_q.result.addr.dw_idx[core_pkg::DMEM_AW-1:0];
        dmem.wdata = pkt_q.store_data << {offs, 3'b000};  // Data onto its lanes
    end

endmodule

// File: source/core_pipe_s3_reg.sv
`timescale 1ns/1ps

module core_pipe_s3_reg (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  s2_valid,   // Memory stage has a packet
    input  core_pkg::instr_pkt_t  s2_pkt,
    input  logic                  s3_ready,   // Writeback can drain
    output logic                  s2_ready,
    output logic                  s3_valid,   // Packet lands at next edge
    output logic                  s3_full,    // Register occupied
    output core_pkg::instr_pkt_t  s3_pkt
);

    logic                 full_q;
    core_pkg::instr_pkt_t pkt_q;
    logic                 load;             // Transfer from stage 2

    // ----------------------------------------
    // One-entry register
    // ----------------------------------------

    assign s2_ready = !full_q || s3_ready;  // Empty or draining this cycle
    assign load     = s2_valid && s2_ready;
    assign s3_valid = load;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            full_q <= 1'b0;
        end else if (load) begin
            full_q <= 1'b1;
        end else if (s3_ready) begin
            full_q <= 1'b0;                 // Drained with nothing behind
        end
    end

    always_ff @(posedge g_clk) begin
        if (load) begin
            pkt_q <= s2_pkt;
        end
    end

    assign s3_full = full_q;
    assign s3_pkt  = pkt_q;

endmodule

// File: source/core_pipe_wb.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_pipe_wb (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  s3_valid,     // New packet at next edge
    input  logic                  s3_full,      // Stage 3 occupied
    input  core_pkg::instr_pkt_t  s3_pkt,
    input  logic [`CORE_XLEN-1:0] dmem_rdata,   // Valid while packet in s3
    input  logic [`CORE_XLEN-1:0] csr_rdata,    // Old CSR value
    input  logic                  csr_error,    // Bad CSR access
    output logic                  s3_ready,
    output core_pkg::gpr_wr_t     gpr_wr,
    output core_pkg::csr_req_t    csr_req,
    output core_pkg::trace_t      trace
);

    logic                  armed_q;             // Fresh packet not yet retired
    logic                  retire;              // Packet retires this cycle
    logic                  csr_any;             // Packet has a CSR op
    logic [`CORE_XLEN-1:0] lsu_rdata;           // Aligned load result
    logic [`CORE_XLEN-1:0] rdata_sh;            // Load data moved to lane 0
    logic [`CORE_XLEN-1:0] rdata_byte;
    logic [`CORE_XLEN-1:0] rdata_half;
    logic [`CORE_XLEN-1:0] rdata_word;
    logic                  sx;                  // Sign extension wanted

    // ----------------------------------------
    // Retire control
    // ----------------------------------------

    assign s3_ready = 1'b1;                     // No control flow wait

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            armed_q <= 1'b0;
        end else begin
            armed_q <= s3_valid && s3_ready;    // One pulse per packet
        end
    end

    assign retire = armed_q && s3_full;

    // ----------------------------------------
    // Load data alignment
    // ----------------------------------------

    assign sx       = s3_pkt.lsu_op.sext;
    assign rdata_sh = dmem_rdata >> {s3_pkt.result.addr.offset, 3'b000};

    // Mask to size, then fill upper bits
    assign rdata_byte = {{(`CORE_XLEN-8){sx && rdata_sh[7]}},   rdata_sh[7:0]};
    assign rdata_half = {{(`CORE_XLEN-16){sx && rdata_sh[15]}}, rdata_sh[15:0]};
    assign rdata_word = {{(`CORE_XLEN-32){sx && rdata_sh[31]}}, rdata_sh[31:0]};

    always_comb begin
        if (s3_pkt.lsu_op.sz_byte) begin
            lsu_rdata = rdata_byte;
        end else if (s3_pkt.lsu_op.sz_half) begin
            lsu_rdata = rdata_half;
        end else if (s3_pkt.lsu_op.sz_word) begin
            lsu_rdata = rdata_word;
        end else begin
            lsu_rdata = dmem_rdata;             // Double, already aligned
        end
    end

    // ----------------------------------------
    // CSR access
    // ----------------------------------------

    assign csr_any = s3_pkt.csr_op.rd || s3_pkt.csr_op.wr ||
                     s3_pkt.csr_op.set || s3_pkt.csr_op.clr;

    always_comb begin
        csr_req.en    = retire && csr_any;      // Once per instruction
        csr_req.wr    = s3_pkt.csr_op.wr;
        csr_req.set   = s3_pkt.csr_op.set;
        csr_req.clr   = s3_pkt.csr_op.clr;
        csr_req.addr  = s3_pkt.csr_addr;
        csr_req.wdata = s3_pkt.result.value;    // Operand from execute
    end

    // ----------------------------------------
    // GPR writeback and trace
    // ----------------------------------------

    always_comb begin
        gpr_wr.wen  = retire && (s3_pkt.wb_op != core_pkg::WB_OP_NONE) && !csr_error;
        gpr_wr.addr = s3_pkt.rd;
        case (s3_pkt.wb_op)
            core_pkg::WB_OP_LSU: gpr_wr.wdata = lsu_rdata;
            core_pkg::WB_OP_CSR: gpr_wr.wdata = csr_rdata;
            default:             gpr_wr.wdata = s3_pkt.result.value;
        endcase
    end

    always_comb begin
        trace.valid = retire;                   // Every retired packet
        trace.instr = s3_pkt.instr;
        trace.pc    = s3_pkt.pc;
    end

endmodule

// File: source/core_csr_file.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_csr_file (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  core_pkg::csr_req_t    csr_req,
    output logic [`CORE_XLEN-1:0] csr_rdata,    // Value before the access
    output logic                  csr_error     // Unknown or read-only write
);

    localparam logic [`CORE_CSR_ADDR_W-1:0] ADDR_MSCRATCH = 'h340;
    localparam logic [`CORE_CSR_ADDR_W-1:0] ADDR_MEPC     = 'h341;
    localparam logic [`CORE_CSR_ADDR_W-1:0] ADDR_MTVAL    = 'h343;
    localparam logic [`CORE_CSR_ADDR_W-1:0] ADDR_MHARTID  = 'hf14;

    logic [`CORE_XLEN-1:0] mscratch_q;
    logic [`CORE_XLEN-1:0] mepc_q;
    logic [`CORE_XLEN-1:0] mtval_q;
    logic [`CORE_XLEN-1:0] new_val;             // Value after the op
    logic sel_scratch, sel_epc, sel_tval, sel_hartid;
    logic is_write;                             // Any modifying op
    logic do_write;

    // ----------------------------------------
    // Decode and read
    // ----------------------------------------

    assign sel_scratch = (csr_req.addr == ADDR_MSCRATCH);
    assign sel_epc     = (csr_req.addr == ADDR_MEPC);
    assign sel_tval    = (csr_req.addr == ADDR_MTVAL);
    assign sel_hartid  = (csr_req.addr == ADDR_MHARTID);
    assign is_write    = csr_req.wr || csr_req.set || csr_req.clr;

    assign csr_error = csr_req.en &&
                       (!(sel_scratch || sel_epc || sel_tval || sel_hartid) ||
                        (sel_hartid && is_write));

    always_comb begin
        if (sel_scratch) begin
            csr_rdata = mscratch_q;
        end else if (sel_epc) begin
            csr_rdata = mepc_q;
        end else if (sel_tval) begin
            csr_rdata = mtval_q;
        end else begin
            csr_rdata = '0;                     // Hart 0, or unknown
        end
    end

    // ----------------------------------------
    // Update
    // ----------------------------------------

    always_comb begin
        if (csr_req.wr) begin
            new_val = csr_req.wdata;
        end else if (csr_req.set) begin
            new_val = csr_rdata | csr_req.wdata;
        end else begin
            new_val = csr_rdata & ~csr_req.wdata;  // Clear
        end
    end

    assign do_write = csr_req.en && is_write && !csr_error;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            mscratch_q <= '0;
            mepc_q     <= '0;
            mtval_q    <= '0;
        end else if (do_write) begin
            if (sel_scratch) mscratch_q <= new_val;
            if (sel_epc)     mepc_q     <= new_val;
            if (sel_tval)    mtval_q    <= new_val;
        end
    end

endmodule

// File: source/core_dmem_sram.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_dmem_sram (
    input  logic                  g_clk,
    input  core_pkg::dmem_req_t   dmem,         // Request from memory stage
    output logic [`CORE_XLEN-1:0] dmem_rdata    // One cycle after request
);

    logic [`CORE_XLEN-1:0] mem [`CORE_DMEM_DEPTH];

    // ----------------------------------------
    // Byte-strobed write, registered read
    // ----------------------------------------

    always_ff @(posedge g_clk) begin
        if (dmem.req && dmem.wen) begin
            for (int i = 0; i < 8; i++) begin
                if (dmem.strb[i]) begin
                    mem[dmem.addr][8*i +: 8] <= dmem.wdata[8*i +: 8];  // Lane i
                end
            end
        end else if (dmem.req) begin
            dmem_rdata <= mem[dmem.addr];       // Load read
        end
    end

endmodule

// File: source/core_pipe_backend.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_pipe_backend (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  iss_req,
    output logic                  iss_ack,
    input  core_pkg::instr_pkt_t  iss_pkt,
    output core_pkg::gpr_wr_t     gpr_wr,       // GPR write port
    output core_pkg::trace_t      trace         // Retire trace
);

    // ----------------------------------------
    // Stage links
    // ----------------------------------------

    logic                  s2_valid;
    logic                  s2_ready;
    core_pkg::instr_pkt_t  s2_pkt;
    logic                  s3_valid;
    logic                  s3_ready;
    logic                  s3_full;
    core_pkg::instr_pkt_t  s3_pkt;
    core_pkg::dmem_req_t   dmem;
    logic [`CORE_XLEN-1:0] dmem_rdata;
    core_pkg::csr_req_t    csr_req;
    logic [`CORE_XLEN-1:0] csr_rdata;
    logic                  csr_error;

    core_pipe_mem core_pipe_mem_inst (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .iss_req  (iss_req),
        .iss_pkt  (iss_pkt),
        .s2_ready (s2_ready),
        .iss_ack  (iss_ack),
        .s2_valid (s2_valid),
        .s2_pkt   (s2_pkt),
        .dmem     (dmem)
    );

    core_pipe_s3_reg core_pipe_s3_reg_inst (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .s2_valid (s2_valid),
        .s2_pkt   (s2_pkt),
        .s3_ready (s3_ready),
        .s2_ready (s2_ready),
        .s3_valid (s3_valid),
        .s3_full  (s3_full),
        .s3_pkt   (s3_pkt)
    );

    core_pipe_wb core_pipe_wb_inst (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .s3_valid   (s3_valid),
        .s3_full    (s3_full),
        .s3_pkt     (s3_pkt),
        .dmem_rdata (dmem_rdata),
        .csr_rdata  (csr_rdata),
        .csr_error  (csr_error),
        .s3_ready   (s3_ready),
        .gpr_wr     (gpr_wr),
        .csr_req    (csr_req),
        .trace      (trace)
    );

    core_csr_file core_csr_file_inst (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .csr_req   (csr_req),
        .csr_rdata (csr_rdata),
        .csr_error (csr_error)
    );

    core_dmem_sram core_dmem_sram_inst (
        .g_clk      (g_clk),
        .dmem       (dmem),
        .dmem_rdata (dmem_rdata)
    );

endmodule

// File: dv/core_backend_tb.sv
`timescale 1ns/1ps
`include "core_cfg.svh"

module core_backend_tb;

    typedef struct packed {
        logic [`CORE_XLEN-1:0]       pc;
        logic [31:0]                 instr;
        logic                        wen;     // GPR write expected
        logic [`CORE_REG_ADDR_W-1:0] rd;
        logic [`CORE_XLEN-1:0]       wdata;
    } exp_t;

    logic                 g_clk;
    logic                 g_resetn;
    logic                 iss_req;
    logic                 iss_ack;
    core_pkg::instr_pkt_t iss_pkt;
    core_pkg::gpr_wr_t    gpr_wr;
    core_pkg::trace_t     trace;

    exp_t                  exp_q[$];             // Retires in issue order
    exp_t                  head;
    logic [7:0]            mem_model [0:8*`CORE_DMEM_DEPTH-1];
    logic [`CORE_XLEN-1:0] csr_model [0:2];      // mscratch, mepc, mtval
    logic [`CORE_XLEN-1:0] pc_ctr;
    logic                  ack_p, req_p;         // Values at previous edge
    int                    errors, tests_run, tests_failed, err_mark;

    core_pipe_backend core_pipe_backend_inst (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .iss_req  (iss_req),
        .iss_ack  (iss_ack),
        .iss_pkt  (iss_pkt),
        .gpr_wr   (gpr_wr),
        .trace    (trace)
    );

    initial begin
        g_clk = 1'b0;
        forever #5 g_clk = ~g_clk;
    end

    // ----------------------------------------
    // Checking at every edge
    // ----------------------------------------

    always @(posedge g_clk) begin
        if (g_resetn) begin
            assert (!(iss_ack && !ack_p) || req_p) else begin
                $display("iss_ack rose while iss_req was low");
                errors++;
            end
            assert (!(!iss_ack && ack_p) || !req_p) else begin
                $display("iss_ack fell while iss_req was still high");
                errors++;
            end
            assert (!(ack_p && !req_p) || !iss_ack) else begin
                $display("iss_ack stayed high after iss_req dropped");
                errors++;
            end
            if (trace.valid) begin
                if (exp_q.size() == 0) begin
                    $display("retire seen with no packet outstanding");
                    errors++;
                end else begin
                    head = exp_q.pop_front();
                    assert (trace.pc == head.pc) else begin
                        $display("CHECK FAILED trace.pc exp %h got %h", head.pc, trace.pc);
                        errors++;
                    end
                    assert (trace.instr == head.instr) else begin
                        $display("CHECK FAILED trace.instr exp %h got %h",
                                 head.instr, trace.instr);
                        errors++;
                    end
                    assert (gpr_wr.wen == head.wen) else begin
                        $display("CHECK FAILED gpr_wr.wen exp %h got %h", head.wen, gpr_wr.wen);
                        errors++;
                    end
                    if (head.wen) begin
                        assert (gpr_wr.addr == head.rd) else begin
                            $display("CHECK FAILED gpr_wr.addr exp %h got %h",
                                     head.rd, gpr_wr.addr);
                            errors++;
                        end
                        assert (gpr_wr.wdata == head.wdata) else begin
                            $display("CHECK FAILED gpr_wr.wdata exp %h got %h",
                                     head.wdata, gpr_wr.wdata);
                            errors++;
                        end
                    end
                end
            end else begin
                assert (!gpr_wr.wen) else begin
                    $display("GPR write seen without a retire");
                    errors++;
                end
            end
        end
        ack_p = iss_ack;
        req_p = iss_req;
    end

    // ----------------------------------------
    // Stimulus helpers
    // ----------------------------------------

    task automatic timed_out(input string what);
        $display("timeout waiting for %s", what);
        $display("TB FAILED");
        $finish;
    endtask

    // Four-phase issue, called right after a rising edge
    task automatic issue(input core_pkg::instr_pkt_t pkt_in, input logic wen,
                         input logic [`CORE_XLEN-1:0] wdata);
        core_pkg::instr_pkt_t pkt;
        exp_t                 e;
        int                   t;
        pkt       = pkt_in;
        pkt.pc    = pc_ctr;
        pkt.instr = $urandom;
        pc_ctr    = pc_ctr + 64'd4;
        e.pc      = pkt.pc;
        e.instr   = pkt.instr;
        e.wen     = wen;
        e.rd      = pkt.rd;
        e.wdata   = wdata;
        exp_q.push_back(e);
        iss_pkt <= pkt;
        iss_req <= 1'b1;
        t = 0;
        while (!iss_ack) begin
            @(posedge g_clk);
            t++;
            if (t > 50) timed_out("iss_ack to rise");
        end
        iss_req <= 1'b0;
        t = 0;
        while (iss_ack) begin
            @(posedge g_clk);
            t++;
            if (t > 50) timed_out("iss_ack to fall");
        end
    endtask

    task automatic exec_op(input logic wen);
        core_pkg::instr_pkt_t p;
        p              = '0;
        p.rd           = 5'($urandom_range(0, 31));
        p.result.value = {$urandom, $urandom};
        p.wb_op        = wen ? core_pkg::WB_OP_WDATA : core_pkg::WB_OP_NONE;
        issue(p, wen, p.result.value);
    endtask

    // Size code 0..3 is byte, half, word, double
    function automatic core_pkg::lsu_op_t size_flags(input int sz);
        core_pkg::lsu_op_t l;
        l           = '0;
        l.sz_byte   = (sz == 0);
        l.sz_half   = (sz == 1);
        l.sz_word   = (sz == 2);
        l.sz_double = (sz == 3);
        return l;
    endfunction

    task automatic mem_op(input logic is_store, input int sz, input logic sext, input int word);
        core_pkg::instr_pkt_t  p;
        logic [`CORE_XLEN-1:0] data, val;
        int                    n, off, base;
        n    = 1 << sz;
        off  = int'($urandom_range(0, 8 / n - 1)) * n;   // Aligned offset
        base = word * 8 + off;
        data = {$urandom, $urandom};
        p              = '0;
        p.lsu_op       = size_flags(sz);
        p.lsu_op.sext  = sext;
        p.result.value = 64'(base);
        p.rd           = 5'($urandom_range(0, 31));
        if (is_store) begin
            p.lsu_op.store = 1'b1;
            p.store_data   = data;
            p.wb_op        = core_pkg::WB_OP_NONE;
            for (int i = 0; i < n; i++) mem_model[base + i] = data[8*i +: 8];
            issue(p, 1'b0, '0);
        end else begin
            p.lsu_op.load = 1'b1;
            p.wb_op       = core_pkg::WB_OP_LSU;
            val = '0;
            for (int i = 0; i < n; i++) val[8*i +: 8] = mem_model[base + i];
            if (sext && n < 8 && val[8*n-1]) begin
                for (int i = 8 * n; i < 64; i++) val[i] = 1'b1;   // Sign fill
            end
            issue(p, 1'b1, val);
        end
    endtask

    // CSR op code 0..3 is read, write, set, clear
    task automatic csr_op(input logic [11:0] addr, input int op, input logic [63:0] operand);
        core_pkg::instr_pkt_t p;
        logic [63:0]          old_v;
        int                   idx;
        logic                 err;
        case (addr)
            12'h340: idx = 0;
            12'h341: idx = 1;
            12'h343: idx = 2;
            12'hf14: idx = 3;
            default: idx = -1;
        endcase
        old_v = (idx >= 0 && idx < 3) ? csr_model[idx] : 64'd0;
        err   = (idx < 0) || (idx == 3 && op != 0);
        if (!err && idx < 3) begin
            if (op == 1) csr_model[idx] = operand;
            if (op == 2) csr_model[idx] = old_v | operand;
            if (op == 3) csr_model[idx] = old_v & ~operand;
        end
        p              = '0;
        p.csr_op.rd    = (op == 0);
        p.csr_op.wr    = (op == 1);
        p.csr_op.set   = (op == 2);
        p.csr_op.clr   = (op == 3);
        p.csr_addr     = addr;
        p.result.value = operand;
        p.rd           = 5'($urandom_range(1, 31));
        p.wb_op        = core_pkg::WB_OP_CSR;
        issue(p, !err, old_v);
    endtask

    task automatic drain_and_report(input int num, input string name);
        int t;
        t = 0;
        while (exp_q.size() != 0) begin
            @(posedge g_clk);
            t++;
            if (t > 200) timed_out("outstanding retires");
        end
        tests_run++;
        if (errors != err_mark) tests_failed++;
        $display("test %0d %s: %s", num, name, (errors != err_mark) ? "fail" : "ok");
        err_mark = errors;
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        logic [11:0] csr_addrs [0:2];
        void'($urandom(32'h536dc711));
        csr_addrs[0] = 12'h340;
        csr_addrs[1] = 12'h341;
        csr_addrs[2] = 12'h343;
        iss_req  = 1'b0;
        iss_pkt  = '0;
        g_resetn = 1'b0;
        pc_ctr   = 64'h8000_0000;
        ack_p    = 1'b0;
        req_p    = 1'b0;
        errors   = 0;
        err_mark = 0;
        tests_run    = 0;
        tests_failed = 0;
        for (int i = 0; i < 3; i++) csr_model[i] = '0;
        repeat (8) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(posedge g_clk);
        assert (!iss_ack && !gpr_wr.wen && !trace.valid) else begin
            $display("outputs not low after reset");
            errors++;
        end
        exec_op(1'b1);
        drain_and_report(1, "handshake and reset");

        repeat (10) exec_op($urandom_range(0, 1) == 1);
        drain_and_report(2, "execute writeback");

        for (int w = 0; w < 16; w++) mem_op(1'b1, 3, 1'b0, w);   // Fill region
        for (int sz = 0; sz < 4; sz++) begin
            mem_op(1'b1, sz, 1'b0, $urandom_range(0, 15));       // Every size once
            mem_op(1'b0, sz, 1'b0, $urandom_range(0, 15));
            mem_op(1'b0, sz, 1'b1, $urandom_range(0, 15));
        end
        repeat (24) mem_op(1'b1, $urandom_range(0, 3), 1'b0, $urandom_range(0, 15));
        repeat (40) begin
            mem_op(1'b0, $urandom_range(0, 3), $urandom_range(0, 1) == 1,
                   $urandom_range(0, 15));
        end
        drain_and_report(3, "loads and stores");

        for (int i = 0; i < 3; i++) begin
            for (int op = 1; op < 4; op++) begin
                csr_op(csr_addrs[i], op, {$urandom, $urandom});   // Write, set, clear
            end
            csr_op(csr_addrs[i], 0, '0);
        end
        repeat (16) csr_op(csr_addrs[$urandom_range(0, 2)], $urandom_range(0, 3),
                           {$urandom, $urandom});
        for (int i = 0; i < 3; i++) csr_op(csr_addrs[i], 0, '0);
        drain_and_report(4, "CSR access");

        csr_op(12'h7c0, 1, {$urandom, $urandom});   // Unknown CSR
        csr_op(12'hf14, 1, {$urandom, $urandom});   // Write to mhartid
        csr_op(12'hf14, 0, '0);
        csr_op(12'h340, 0, '0);
        drain_and_report(5, "CSR error");

        repeat (20) exec_op(1'b1);
        repeat (20) begin
            repeat ($urandom_range(0, 4)) @(posedge g_clk);
            exec_op($urandom_range(0, 1) == 1);
        end
        drain_and_report(6, "back-to-back retire");

        $display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+include
source/core_pkg.sv
source/core_pipe_mem.sv
source/core_pipe_s3_reg.sv
source/core_pipe_wb.sv
source/core_csr_file.sv
source/core_dmem_sram.sv
source/core_pipe_backend.sv
dv/core_backend_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the back end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module core_backend_tb -o sim_core_backend

out=$(./obj_dir/sim_core_backend)
echo "$out"

# Fails the script unless the pass message was printed
echo "$out" | grep -q "^TB PASSED$"
